// ==== stack_cpu_top.f ====
+incdir+include
hw/stack_cpu_pkg.sv
hw/boot_loader.sv
hw/code_ram.sv
hw/stack_ram.sv
hw/stack_cpu_core.sv
hw/stack_cpu_top.sv
verification/stack_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: stack_cpu

sources:
  # design, package first
  - files:
      - hw/stack_cpu_pkg.sv
      - hw/boot_loader.sv
      - hw/code_ram.sv
      - hw/stack_ram.sv
      - hw/stack_cpu_core.sv
      - hw/stack_cpu_top.sv

  # testbench, includes the program images
  - target: test
    include_dirs:
      - include
    files:
      - verification/stack_cpu_tb.sv

// ==== include/stack_cpu_programs.svh ====
// stack cpu test programs: images, operand slots and expected wrReg sequences
`ifndef STACK_CPU_PROGRAMS_SVH
`define STACK_CPU_PROGRAMS_SVH

////////////////////////////////////////
// stack rules, fixed values
// each wrReg pops what it writes

localparam int STACK_LEN = 23;
localparam insn_t PROG_STACK [STACK_LEN] = '{
    16'h0001, 16'h0002, 16'h0003, 16'h8100,     // 1 2 3, dup
    16'hD001, 16'h8200, 16'hD002, 16'h8400,     // wr 3, swap, wr 2, over
    16'hD003, 16'h8500, 16'h0004, 16'h0005,     // wr 1, drop, 4 5
    16'h8600, 16'hD004, 16'hD005, 16'h9E00,     // rot, wr 1, wr 5, to_r
    16'h0006, 16'h9C00, 16'hD006, 16'h9D00,     // 6, r, wr 4, r_from
    16'hD007, 16'hD008, 16'hE000                // wr 4, wr 6, end
};
localparam word_t   EXP_STACK     [8] = '{3, 2, 1, 1, 5, 4, 4, 6};
localparam io_sel_t EXP_STACK_SEL [8] = '{1, 2, 3, 4, 5, 6, 7, 8};

////////////////////////////////////////
// control flow
// wrReg 9 sits only on paths that must not run

localparam int CTRL_LEN = 20;
localparam insn_t PROG_CTRL [CTRL_LEN] = '{
    16'h0000, 16'hB008, 16'hD009, 16'hE000,     // 0, bz 4 taken
    16'h0001, 16'hB010, 16'h0002, 16'hB015,     // bz 8 falls, bnz 10 taken
    16'hD009, 16'hE000, 16'h0007, 16'hA020,     // 7, call 16
    16'hD002, 16'h0000, 16'hB011, 16'hA023,     // wr 8, bnz falls, br 17
    16'h8781, 16'h0005, 16'hD003, 16'hE000      // addi 1 + return, 5, wr 5
};
localparam word_t   EXP_CTRL     [2] = '{8, 5};
localparam io_sel_t EXP_CTRL_SEL [2] = '{2, 3};

////////////////////////////////////////
// alu, operands a and b patched in by the testbench
// wr 1..12: a+b a-b a&b a|b a^b ~b b<<1 ~b>>>1 swap16(b) b+5 0 a+b+1

localparam int ALU_LEN    = 48;
localparam int ALU_SLOT_A = 0;
localparam int ALU_SLOT_B = 1;
localparam insn_t PROG_ALU [ALU_LEN] = '{
    16'h0000, 16'h0000,
    16'h8400, 16'h8400, 16'h8800, 16'hD001,     // over over add
    16'h8400, 16'h8400, 16'h8900, 16'hD002,
    16'h8400, 16'h8400, 16'h8B00, 16'hD003,
    16'h8400, 16'h8400, 16'h8C00, 16'hD004,
    16'h8400, 16'h8400, 16'h8D00, 16'hD005,
    16'h8100, 16'h8E00, 16'hD006,               // dup not
    16'h8100, 16'h9100, 16'hD007,
    16'h8100, 16'h8E00, 16'h9200, 16'hD008,     // negative operand for shr
    16'h8100, 16'h8300, 16'hD009,
    16'h8100, 16'h8705, 16'hD00A,               // dup addi 5
    16'h0000, 16'h8E00, 16'h0001, 16'h8800,     // all ones + 1 sets carry
    16'hD00B,
    16'h8400, 16'h8400, 16'h8840, 16'hD00C,     // add with carry-in
    16'hE000
};

////////////////////////////////////////
// memory and input
// slots hold data d and even address a, a used twice
// ~d is stored so bit 15 is set in the fetched half
// wr 1..4: a+2, low half of ~d, par, {ser0, ser1, ser2}

localparam int MEM_LEN     = 16;
localparam int MEM_SLOT_D  = 0;
localparam int MEM_SLOT_A  = 2;
localparam int MEM_SLOT_A2 = 5;
localparam insn_t PROG_MEM [MEM_LEN] = '{
    16'h0000, 16'h8E00, 16'h0000, 16'h9500,     // d not a, store16
    16'hD001,
    16'h0000, 16'h9400, 16'hD002,               // fetch16 back
    16'hC005, 16'hD003,                         // rdReg 5
    16'h0000, 16'h9300, 16'h9320, 16'h9340,     // three rdBit
    16'hD004, 16'hE000
};

`endif

// ==== verification/stack_cpu_tb.sv ====
// stack cpu testbench: loads each program image, runs it and checks the i/o strobes
module stack_cpu_tb
    import stack_cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "stack_cpu_programs.svh"

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 8;
    localparam logic [31:0] SEED          = 32'hb4696588;
    // cycles per program word, plus reset and start-up per test
    localparam int          CYCLE_BUDGET  = 6;
    localparam int          TEST_OVERHEAD = 24;
    localparam int          NUM_TESTS     = 4;
    localparam int          TOTAL_WORDS   = STACK_LEN + CTRL_LEN + ALU_LEN + MEM_LEN;
    localparam int          WATCHDOG_NS   =
        (TOTAL_WORDS * CYCLE_BUDGET + NUM_TESTS * TEST_OVERHEAD) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       load_valid;
    logic       load_last;
    insn_t      par;
    logic [2:0] ser;
    logic       running;
    word_t      tos;
    io_sel_t    io_sel;
    io_strobe_t strobes;

    // per test state
    string   test_name;
    insn_t   image [64];
    word_t   exp_val [$];
    io_sel_t exp_sel [$];
    word_t   got_val [$];
    int      exp_rd_bits;
    int      exp_rd_regs;
    int      first_exec;
    int      exec_count;
    int      rd_bit_count;
    int      rd_reg_count;
    bit      seen_strobe;
    bit      done;
    insn_t   rd_value;
    int      errors;
    int      checks;

    stack_cpu_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .par        (par),
        .ser        (ser),
        .running    (running),
        .tos        (tos),
        .io_sel     (io_sel),
        .strobes    (strobes)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // responder and checks, mid-cycle

    always @(negedge clk) begin
        int idx;
        if (rst_n && !done) begin
            assert (running || strobes == '0) else begin
                $display("ERROR %s: strobe high while the core is held", test_name);
                errors++;
            end
            assert (!(strobes.rd_reg2 || strobes.wr_reg2 || strobes.wr_evt2)) else begin
                $display("ERROR %s: second bank strobe fired", test_name);
                errors++;
            end
            if (running) begin
                exec_count++;
            end
            // first strobe pins down where word 0 ran
            if (strobes != '0 && !seen_strobe) begin
                seen_strobe = 1'b1;
                checks++;
                assert (exec_count == first_exec) else begin
                    $display("MISMATCH %s first strobe: expected insn %0d, actual %0d",
                             test_name, first_exec, exec_count);
                    errors++;
                end
            end
            if (strobes.wr_reg) begin
                got_val.push_back(tos);
                idx = got_val.size() - 1;
                checks++;
                assert (idx < exp_val.size()) else begin
                    $display("ERROR %s: register write %0d was not expected", test_name, idx);
                    errors++;
                end
                if (idx < exp_val.size()) begin
                    assert (tos == exp_val[idx] && io_sel == exp_sel[idx]) else begin
                        $display("MISMATCH %s write %0d: expected %h sel %0d, actual %h sel %0d",
                                 test_name, idx, exp_val[idx], exp_sel[idx], tos, io_sel);
                        errors++;
                    end
                end
            end
            // rdBit strobes come in bit order 0, 1, 2
            if (strobes.rd_bit != 3'b000) begin
                checks++;
                assert (strobes.rd_bit == 3'(1 << rd_bit_count)) else begin
                    $display("MISMATCH %s rd_bit: expected %b, actual %b",
                             test_name, 3'(1 << rd_bit_count), strobes.rd_bit);
                    errors++;
                end
                rd_bit_count++;
            end
            // sampled into tos on the closing edge
            if (strobes.rd_reg) begin
                par = rd_value;
                rd_reg_count++;
            end
            if (strobes.wr_evt) begin
                done = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // test cases

    task automatic clear_case();
        exp_val.delete();
        exp_sel.delete();
        exp_rd_bits = 0;
        exp_rd_regs = 0;
    endtask

    task automatic expect_write(input word_t val, input io_sel_t sel);
        exp_val.push_back(val);
        exp_sel.push_back(sel);
    endtask

    task automatic fill_stack_case();
        clear_case();
        foreach (PROG_STACK[i]) begin
            image[i] = PROG_STACK[i];
        end
        foreach (EXP_STACK[i]) begin
            expect_write(EXP_STACK[i], EXP_STACK_SEL[i]);
        end
    endtask

    task automatic fill_control_case();
        clear_case();
        foreach (PROG_CTRL[i]) begin
            image[i] = PROG_CTRL[i];
        end
        foreach (EXP_CTRL[i]) begin
            expect_write(EXP_CTRL[i], EXP_CTRL_SEL[i]);
        end
    endtask

    task automatic build_alu_case();
        word_t a;
        word_t b;
        a = word_t'($urandom & 32'h7FFF);
        b = word_t'($urandom & 32'h7FFF);
        clear_case();
        foreach (PROG_ALU[i]) begin
            image[i] = PROG_ALU[i];
        end
        image[ALU_SLOT_A] = {1'b0, a[14:0]};
        image[ALU_SLOT_B] = {1'b0, b[14:0]};
        expect_write(a + b, 1);
        expect_write(a - b, 2);
        expect_write(a & b, 3);
        expect_write(a | b, 4);
        expect_write(a ^ b, 5);
        expect_write(~b, 6);
        expect_write(b << 1, 7);
        expect_write(word_t'($signed(~b) >>> 1), 8);
        expect_write((b << 16) | (b >> 16), 9);
        expect_write(b + 5, 10);
        // all ones plus one wraps to zero, carry out set
        expect_write(32'd0, 11);
        expect_write(a + b + 1, 12);
    endtask

    task automatic build_memory_case();
        word_t      data;
        word_t      addr;
        logic [2:0] bits;
        data = word_t'($urandom & 32'h7FFF);
        // even byte address, word index clear of the program
        addr = word_t'((16 + $urandom % 2032) * 2);
        rd_value = insn_t'($urandom);
        bits = 3'($urandom);
        ser = bits;
        clear_case();
        foreach (PROG_MEM[i]) begin
            image[i] = PROG_MEM[i];
        end
        image[MEM_SLOT_D]  = {1'b0, data[14:0]};
        image[MEM_SLOT_A]  = {1'b0, addr[14:0]};
        image[MEM_SLOT_A2] = {1'b0, addr[14:0]};
        expect_write(addr + 2, 1);
        // inverted half, upper 16 bits must stay clear
        expect_write({16'h0000, ~data[15:0]}, 2);
        expect_write(word_t'(rd_value), 3);
        // first bit read ends up highest
        expect_write(word_t'({bits[0], bits[1], bits[2]}), 4);
        exp_rd_bits = 3;
        exp_rd_regs = 1;
    endtask

    // reset, stream the image in, run until wrEvt
    task automatic run_program(input string name, input int len, input int first);
        int errors_before;
        int i;
        errors_before = errors;
        @(negedge clk);
        rst_n        = 1'b0;
        load_valid   = 1'b0;
        load_last    = 1'b0;
        done         = 1'b0;
        test_name    = name;
        first_exec   = first;
        // the first running cycle still holds a nop
        exec_count   = -2;
        seen_strobe  = 1'b0;
        rd_bit_count = 0;
        rd_reg_count = 0;
        got_val.delete();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < len; i++) begin
            par        = image[i];
            load_valid = 1'b1;
            load_last  = (i == len - 1);
            @(negedge clk);
        end
        load_valid = 1'b0;
        load_last  = 1'b0;
        par        = '0;
        wait (done);
        checks += 3;
        assert (got_val.size() == exp_val.size()) else begin
            $display("ERROR %s: %0d register writes seen, %0d expected",
                     name, got_val.size(), exp_val.size());
            errors++;
        end
        assert (rd_bit_count == exp_rd_bits) else begin
            $display("ERROR %s: %0d rdBit strobes seen, %0d expected",
                     name, rd_bit_count, exp_rd_bits);
            errors++;
        end
        assert (rd_reg_count == exp_rd_regs) else begin
            $display("ERROR %s: %0d rdReg strobes seen, %0d expected",
                     name, rd_reg_count, exp_rd_regs);
            errors++;
        end
        $display("test %s finished: %0d writes, %0d errors",
                 name, got_val.size(), errors - errors_before);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_last  = 1'b0;
        par        = '0;
        ser        = '0;
        done       = 1'b0;
        errors     = 0;
        checks     = 0;
        rd_value   = '0;
        test_name  = "none";
        void'($urandom(SEED));
        fill_stack_case();
        run_program("stack", STACK_LEN, 4);
        // bz, bz, bnz, call and return come before the first write
        fill_control_case();
        run_program("control", CTRL_LEN, 9);
        build_alu_case();
        run_program("alu", ALU_LEN, 5);
        build_memory_case();
        run_program("memory_io", MEM_LEN, 4);
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired during test %s, no wrEvt seen", test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hw/stack_cpu_top.sv ====
// stack cpu top: boot loader, code memory, stack memories and core
module stack_cpu_top
    import stack_cpu_pkg::*;
#(
    parameter int CODE_ADDR_W  = 11,
    parameter int STACK_ADDR_W = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_valid,
    input  logic       load_last,
    input  insn_t      par,
    input  logic [2:0] ser,
    output logic       running,
    output word_t      tos,
    output io_sel_t    io_sel,
    output io_strobe_t strobes
);

    code_wr_t    load_wr, data_wr;
    code_addr_t  fetch_addr, data_addr;
    insn_t       insn, data_rd;
    stack_port_t dstk, rstk;
    word_t       dstk_dout, rstk_dout;

    boot_loader #(.CODE_ADDR_W(CODE_ADDR_W)) u_boot_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .par        (par),
        .code_wr    (load_wr),
        .running    (running)
    );

    code_ram #(.CODE_ADDR_W(CODE_ADDR_W)) u_code_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .running    (running),
        .fetch_addr (fetch_addr),
        .insn       (insn),
        .load_wr    (load_wr),
        .data_wr    (data_wr),
        .data_addr  (data_addr),
        .data_rd    (data_rd)
    );

    stack_ram #(.STACK_ADDR_W(STACK_ADDR_W)) u_stack_ram (
        .clk        (clk),
        .dstk       (dstk),
        .rstk       (rstk),
        .dstk_dout  (dstk_dout),
        .rstk_dout  (rstk_dout)
    );

    stack_cpu_core #(
        .CODE_ADDR_W  (CODE_ADDR_W),
        .STACK_ADDR_W (STACK_ADDR_W)
    ) u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .running    (running),
        .insn       (insn),
        .fetch_addr (fetch_addr),
        .data_addr  (data_addr),
        .data_wr    (data_wr),
        .data_rd    (data_rd),
        .dstk       (dstk),
        .rstk       (rstk),
        .dstk_dout  (dstk_dout),
        .rstk_dout  (rstk_dout),
        .par        (par),
        .ser        (ser),
        .tos        (tos),
        .io_sel     (io_sel),
        .strobes    (strobes)
    );

endmodule

// ==== hw/stack_cpu_core.sv ====
// stack cpu core: decode, alu, tos/nos, pc and stack pointers, i/o strobes
module stack_cpu_core
    import stack_cpu_pkg::*;
#(
    parameter int CODE_ADDR_W  = 11,
    parameter int STACK_ADDR_W = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        running,
    input  insn_t       insn,
    output code_addr_t  fetch_addr,
    output code_addr_t  data_addr,
    output code_wr_t    data_wr,
    input  insn_t       data_rd,
    output stack_port_t dstk,
    output stack_port_t rstk,
    input  word_t       dstk_dout,
    input  word_t       rstk_dout,
    input  insn_t       par,
    input  logic [2:0]  ser,
    output word_t       tos,
    output io_sel_t     io_sel,
    output io_strobe_t  strobes
);

    logic [3:0]  op4;
    logic [7:0]  op8;
    insn_t       op5;
    logic        is_push, opt_ret, opt_cin, serial, nz, jump;
    logic        inc_sp, dec_sp, inc_rp, dec_rp, dstk_wr, rstk_wr;
    logic        carry, ci, co;
    word_t       nos, add_a, add_b, sum, alu, next_tos, ret_addr;
    code_addr_t  pc, next_pc;
    stack_addr_t sp, next_sp, rp, next_rp;

    ////////////////////////////////////////
    // decode

    assign op4 = insn[15:12];
    assign op8 = insn[15:8];
    assign op5 = insn & 16'hF001;   // jump group, dest masked off

    assign is_push = ~insn[15];
    assign opt_ret = insn[7] && insn[15:13] == 3'b100;
    assign opt_cin = insn[6];

    // rdBit source bit
    assign serial = (insn[6:5] == 2'd0) ? ser[0] :
                    (insn[6:5] == 2'd1) ? ser[1] : ser[2];

    // conditions look at the low half only
    assign nz   = |tos[15:0];
    assign jump = op5 == OP_CALL || op5 == OP_BRANCH ||
                  (op5 == OP_BRANCHZ && !nz) || (op5 == OP_BRANCHNZ && nz);

    assign inc_sp = is_push || op4 == OP_RDREG || op8 == OP_DUP ||
                    op8 == OP_OVER || op8 == OP_R || op8 == OP_R_FROM;
    assign dec_sp = op4 == OP_WRREG || op5 == OP_BRANCHZ || op5 == OP_BRANCHNZ ||
                    op8 == OP_DROP || op8 == OP_ADD || op8 == OP_SUB ||
                    op8 == OP_AND || op8 == OP_OR || op8 == OP_XOR ||
                    op8 == OP_TO_R || op8 == OP_STORE16;

    assign inc_rp = op8 == OP_TO_R || op5 == OP_CALL;
    assign dec_rp = op8 == OP_R_FROM || opt_ret;

    // rot rewrites the third entry in place
    assign dstk_wr = inc_sp || op8 == OP_ROT;
    assign rstk_wr = inc_rp;

    ////////////////////////////////////////
    // alu

    // addi immediate, store16 address step, else nos
    assign add_a = (op8 == OP_ADDI)    ? word_t'(insn[6:0]) :
                   (op8 == OP_STORE16) ? word_t'(2)         : nos;
    assign add_b = (op8 == OP_SUB) ? ~tos : tos;
    assign ci    = (op8 == OP_ADD && opt_cin && carry) || op8 == OP_SUB;

    assign {co, sum} = {1'b0, add_a} + {1'b0, add_b} + 33'(ci);

    always_comb begin
        if (is_push) begin
            alu = word_t'(insn[14:0]);
        end else begin
            case (op8)
                OP_ADD, OP_ADDI,
                OP_SUB, OP_STORE16: alu = sum;
                OP_AND:             alu = nos & tos;
                OP_OR:              alu = nos | tos;
                OP_XOR:             alu = nos ^ tos;
                OP_NOT:             alu = ~tos;
                OP_SHL:             alu = {tos[30:0], 1'b0};
                OP_SHR:             alu = {tos[31], tos[31:1]};
                default:            alu = tos;
            endcase
        end
    end

    ////////////////////////////////////////
    // next tos

    always_comb begin
        case (op4)
            OP_BRANCHZ[15:12],                  // bz and bnz pop
            OP_WRREG:           next_tos = nos;
            OP_RDREG:           next_tos = word_t'(par);
            default: begin
                case (op8)
                    OP_SWAP, OP_OVER,
                    OP_DROP, OP_TO_R:   next_tos = nos;
                    OP_ROT:             next_tos = dstk_dout;
                    OP_R, OP_R_FROM:    next_tos = rstk_dout;
                    OP_SWAP16:          next_tos = {tos[15:0], tos[31:16]};
                    OP_RDBIT:           next_tos = {tos[30:0], serial};
                    OP_FETCH16:         next_tos = word_t'(data_rd);
                    default:            next_tos = alu;
                endcase
            end
        endcase
    end

    ////////////////////////////////////////
    // pc and pointers

    always_comb begin
        if (opt_ret) begin
            next_pc = rstk_dout[CODE_ADDR_W:1];
        end else if (jump) begin
            next_pc = insn[CODE_ADDR_W:1];
        end else begin
            next_pc = pc + CODE_ADDR_W'(1);
        end
    end

    assign next_sp = sp + STACK_ADDR_W'(inc_sp) - STACK_ADDR_W'(dec_sp);
    assign next_rp = rp + STACK_ADDR_W'(inc_rp) - STACK_ADDR_W'(dec_rp);

    // byte address of the word after the call
    assign ret_addr = word_t'({pc + CODE_ADDR_W'(1), 1'b0});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '1;
            sp    <= '0;
            rp    <= '0;
            tos   <= '0;
            nos   <= '0;
            carry <= 1'b0;
        end else begin
            // held at all ones so the first run edge wraps to 0
            pc  <= running ? next_pc : '1;
            sp  <= next_sp;
            rp  <= next_rp;
            tos <= next_tos;
            if (op8 == OP_ADD) begin
                carry <= co;
            end
            case (op8)
                OP_SWAP, OP_ROT: nos <= tos;
                default: begin
                    if (inc_sp) begin
                        nos <= tos;
                    end else if (dec_sp) begin
                        nos <= dstk_dout;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // memory ports

    assign fetch_addr = next_pc;
    // read address follows next tos so fetch16 finds data_rd ready
    assign data_addr  = next_tos[CODE_ADDR_W:1];
    assign data_wr    = '{en: op8 == OP_STORE16, addr: tos[CODE_ADDR_W:1], data: nos[15:0]};

    assign dstk = '{we: dstk_wr, addr: next_sp, din: nos};
    assign rstk = '{we: rstk_wr, addr: next_rp, din: (op5 == OP_CALL) ? ret_addr : tos};

    ////////////////////////////////////////
    // i/o strobes, one cycle each

    assign io_sel = insn[10:0];

    always_comb begin
        strobes.rd_bit[0] = op8 == OP_RDBIT && insn[6:5] == 2'd0;
        strobes.rd_bit[1] = op8 == OP_RDBIT && insn[6:5] == 2'd1;
        strobes.rd_bit[2] = op8 == OP_RDBIT && insn[6:5] == 2'd2;
        // insn[11] picks the second bank
        strobes.rd_reg    = op4 == OP_RDREG && !insn[11];
        strobes.rd_reg2   = op4 == OP_RDREG && insn[11];
        strobes.wr_reg    = op4 == OP_WRREG && !insn[11];
        strobes.wr_reg2   = op4 == OP_WRREG && insn[11];
        strobes.wr_evt    = op4 == OP_WREVT && !insn[11];
        strobes.wr_evt2   = op4 == OP_WREVT && insn[11];
    end

endmodule

// ==== hw/stack_ram.sv ====
// data and return stack memories, one synchronous write-first port each
module stack_ram
    import stack_cpu_pkg::*;
#(
    parameter int STACK_ADDR_W = 8
) (
    input  logic        clk,
    input  stack_port_t dstk,
    input  stack_port_t rstk,
    output word_t       dstk_dout,
    output word_t       rstk_dout
);

    word_t dmem [2**STACK_ADDR_W];
    word_t rmem [2**STACK_ADDR_W];

    ////////////////////////////////////////
    // data stack
    // address is the new sp, so dout is the entry under nos

    always_ff @(posedge clk) begin
        if (dstk.we) begin
            dmem[dstk.addr] <= dstk.din;
            dstk_dout       <= dstk.din;
        end else begin
            dstk_dout <= dmem[dstk.addr];
        end
    end

    ////////////////////////////////////////
    // return stack
    // dout is the top entry

    always_ff @(posedge clk) begin
        if (rstk.we) begin
            rmem[rstk.addr] <= rstk.din;
            rstk_dout       <= rstk.din;
        end else begin
            rstk_dout <= rmem[rstk.addr];
        end
    end

endmodule

// ==== hw/code_ram.sv ====
// code and data memory: fetch port plus shared load / store16 / fetch16 port
module code_ram
    import stack_cpu_pkg::*;
#(
    parameter int CODE_ADDR_W = 11
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       running,
    input  code_addr_t fetch_addr,
    output insn_t      insn,
    input  code_wr_t   load_wr,
    input  code_wr_t   data_wr,
    input  code_addr_t data_addr,
    output insn_t      data_rd
);

    insn_t      mem [2**CODE_ADDR_W];
    code_wr_t   port_b_wr;
    code_addr_t port_b_addr;

    // port b owner follows the run state
    assign port_b_wr   = running ? data_wr : load_wr;
    assign port_b_addr = port_b_wr.en ? port_b_wr.addr : data_addr;

    // port b, write first
    always_ff @(posedge clk) begin
        if (port_b_wr.en) begin
            mem[port_b_addr] <= port_b_wr.data;
            data_rd          <= port_b_wr.data;
        end else begin
            data_rd <= mem[port_b_addr];
        end
    end

    // port a, instruction register
    // nop while held so the core idles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            insn <= OP_NOP;
        end else if (!running) begin
            insn <= OP_NOP;
        end else if (port_b_wr.en && port_b_wr.addr == fetch_addr) begin
            insn <= port_b_wr.data;
        end else begin
            insn <= mem[fetch_addr];
        end
    end

endmodule

// ==== hw/boot_loader.sv ====
// boot loader: writes the streamed program image into code memory, then starts the core
module boot_loader
    import stack_cpu_pkg::*;
#(
    parameter int CODE_ADDR_W = 11
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_valid,
    input  logic     load_last,
    input  insn_t    par,
    output code_wr_t code_wr,
    output logic     running
);

    cpu_state_e state;
    code_addr_t load_addr;

    // one write per sampled word, only while loading
    assign code_wr = '{
        en:   (state == ST_LOAD) && load_valid,
        addr: load_addr,
        data: par
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_LOAD;
            load_addr <= '0;
            running   <= 1'b0;
        end else begin
            // one edge behind the state change
            running <= (state == ST_RUN);
            if (code_wr.en) begin
                load_addr <= load_addr + CODE_ADDR_W'(1);
                // last word written on this edge
                if (load_last) begin
                    state <= ST_RUN;
                end
            end
        end
    end

endmodule

// ==== hw/stack_cpu_pkg.sv ====
// stack cpu package: word types, instruction encodings, loader states, port structs
package stack_cpu_pkg;

    ////////////////////////////////////////
    // widths with a meaning

    typedef logic [31:0] word_t;        // tos, nos and stack entries
    typedef logic [15:0] insn_t;        // one instruction, one code word
    typedef logic [10:0] code_addr_t;   // code memory word address
    typedef logic [7:0]  stack_addr_t;  // data or return stack pointer
    typedef logic [10:0] io_sel_t;      // insn[10:0] on i/o instructions

    ////////////////////////////////////////
    // instruction set
    // 0iii_iiii_iiii_iiii  push 15-bit literal
    // 100p_pppp_R...       alu group, R = return
    // 1010/1011 + dest     call, branch, bz, bnz
    // 1100..1110 + bank    rdReg, wrReg, wrEvt

    localparam insn_t       OP_NOP      = 16'h8000;
    localparam logic [7:0]  OP_DUP      = 8'h81;
    localparam logic [7:0]  OP_SWAP     = 8'h82;
    localparam logic [7:0]  OP_SWAP16   = 8'h83;
    localparam logic [7:0]  OP_OVER     = 8'h84;
    localparam logic [7:0]  OP_DROP     = 8'h85;
    localparam logic [7:0]  OP_ROT      = 8'h86;
    localparam logic [7:0]  OP_ADDI     = 8'h87;   // imm in insn[6:0]
    localparam logic [7:0]  OP_ADD      = 8'h88;   // carry-in enable in insn[6]
    localparam logic [7:0]  OP_SUB      = 8'h89;
    localparam logic [7:0]  OP_AND      = 8'h8B;
    localparam logic [7:0]  OP_OR       = 8'h8C;
    localparam logic [7:0]  OP_XOR      = 8'h8D;
    localparam logic [7:0]  OP_NOT      = 8'h8E;
    localparam logic [7:0]  OP_SHL      = 8'h91;
    localparam logic [7:0]  OP_SHR      = 8'h92;   // arithmetic
    localparam logic [7:0]  OP_RDBIT    = 8'h93;   // ser bit in insn[6:5]
    localparam logic [7:0]  OP_FETCH16  = 8'h94;
    localparam logic [7:0]  OP_STORE16  = 8'h95;   // ( d a -- a+2 )
    localparam logic [7:0]  OP_R        = 8'h9C;
    localparam logic [7:0]  OP_R_FROM   = 8'h9D;
    localparam logic [7:0]  OP_TO_R     = 8'h9E;
    localparam insn_t       OP_CALL     = 16'hA000; // dest in insn[11:1]
    localparam insn_t       OP_BRANCH   = 16'hA001;
    localparam insn_t       OP_BRANCHZ  = 16'hB000;
    localparam insn_t       OP_BRANCHNZ = 16'hB001;
    localparam logic [3:0]  OP_RDREG    = 4'hC;     // bank in insn[11]
    localparam logic [3:0]  OP_WRREG    = 4'hD;
    localparam logic [3:0]  OP_WREVT    = 4'hE;

    ////////////////////////////////////////
    // loader state

    typedef enum logic {
        ST_LOAD,    // image streaming in, core held
        ST_RUN
    } cpu_state_e;

    ////////////////////////////////////////
    // grouped signals

    typedef struct packed {
        logic [2:0] rd_bit;
        logic       rd_reg;
        logic       rd_reg2;
        logic       wr_reg;
        logic       wr_reg2;
        logic       wr_evt;
        logic       wr_evt2;
    } io_strobe_t;

    typedef struct packed {
        logic       en;
        code_addr_t addr;
        insn_t      data;
    } code_wr_t;

    typedef struct packed {
        logic        we;
        stack_addr_t addr;
        word_t       din;
    } stack_port_t;

endpackage
